/* sim.f */
+incdir+sim
rtl/irq_pkg.sv
rtl/irq_source_sync.sv
rtl/irq_pending_regs.sv
rtl/irq_priority_encoder.sv
rtl/irq_subsystem_top.sv
sim/tb_irq_subsystem.sv

/* Bender.yml */
package:
  name: irq_subsystem

sources:
  # design sources in compile order
  - files:
      - rtl/irq_pkg.sv
      - rtl/irq_source_sync.sv
      - rtl/irq_pending_regs.sv
      - rtl/irq_priority_encoder.sv
      - rtl/irq_subsystem_top.sv

  # testbench, which includes the step table from sim
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_irq_subsystem.sv

/* sim/tb_irq_vectors.svh */
// step table for the interrupt block testbench with stimulus and expected register and output values.

`ifndef TB_IRQ_VECTORS_SVH
`define TB_IRQ_VECTORS_SVH

	//////////////////////////////////////////////////////////////////////
	// step format
	//////////////////////////////////////////////////////////////////////

	localparam int NAME_BITS = 8 * 24;

	// line steps drive irq_lines, write steps pulse wr once, read steps
	// check data_out and output steps check interrupt and irq_num.
	typedef enum logic [1:0] {
		STEP_LINES,
		STEP_WRITE,
		STEP_READ,
		STEP_OUTPUT
	} step_kind_t;

	typedef struct packed {
		logic [NAME_BITS-1:0] name;
		step_kind_t           kind;
		irq_pkg::reg_addr_t   addr;
		irq_pkg::reg_data_t   data;
		irq_pkg::irq_vec_t    lines;
		logic [7:0]           wait_cycles;
		irq_pkg::reg_data_t   expected;
	} step_t;

	step_t steps[$];

	task automatic add_step(
		input logic [NAME_BITS-1:0] name,
		input step_kind_t           kind,
		input irq_pkg::reg_addr_t   addr,
		input irq_pkg::reg_data_t   data,
		input irq_pkg::irq_vec_t    lines,
		input logic [7:0]           wait_cycles,
		input irq_pkg::reg_data_t   expected
	);
		step_t s;
		s.name        = name;
		s.kind        = kind;
		s.addr        = addr;
		s.data        = data;
		s.lines       = lines;
		s.wait_cycles = wait_cycles;
		s.expected    = expected;
		steps.push_back(s);
	endtask

	//////////////////////////////////////////////////////////////////////
	// the table
	//////////////////////////////////////////////////////////////////////

	// each step gives a name, kind, address, data, lines, wait cycles and expected value.
	// for output steps the expected value holds interrupt in bit 4 and irq_num in bits 3:0.
	task automatic load_steps();
		// reset values and unused addresses.
		add_step("rst_read_enable",     STEP_READ,   4'h0, 16'h0000, 4'b0000, 0, 16'h0000);
		add_step("rst_read_pending",    STEP_READ,   4'h1, 16'h0000, 4'b0000, 0, 16'h0000);
		add_step("rst_outputs",         STEP_OUTPUT, 4'h0, 16'h0000, 4'b0000, 0, 16'h0000);
		add_step("unused_write_5",      STEP_WRITE,  4'h5, 16'hffff, 4'b0000, 1, 16'h0000);
		add_step("unused_read_5",       STEP_READ,   4'h5, 16'h0000, 4'b0000, 0, 16'h0000);
		add_step("unused_write_8",      STEP_WRITE,  4'h8, 16'ha5a5, 4'b0000, 1, 16'h0000);
		add_step("unused_read_8",       STEP_READ,   4'h8, 16'h0000, 4'b0000, 0, 16'h0000);
		add_step("unused_enable_kept",  STEP_READ,   4'h0, 16'h0000, 4'b0000, 0, 16'h0000);
		// mask readback and a masked request.
		add_step("enable_write",        STEP_WRITE,  4'h0, 16'hfff5, 4'b0000, 1, 16'h0000);
		add_step("enable_readback",     STEP_READ,   4'h0, 16'h0000, 4'b0000, 0, 16'h0005);
		add_step("enable_clear",        STEP_WRITE,  4'h0, 16'h0000, 4'b0000, 1, 16'h0000);
		add_step("enable_cleared",      STEP_READ,   4'h0, 16'h0000, 4'b0000, 0, 16'h0000);
		add_step("vsync_rise",          STEP_LINES,  4'h0, 16'h0000, 4'b0010, 8, 16'h0000);
		add_step("vsync_pending",       STEP_READ,   4'h1, 16'h0000, 4'b0000, 0, 16'h0002);
		add_step("masked_quiet",        STEP_OUTPUT, 4'h0, 16'h0000, 4'b0000, 0, 16'h0000);
		// priority among several enabled pending bits.
		add_step("audio_flash_rise",    STEP_LINES,  4'h0, 16'h0000, 4'b1110, 8, 16'h0000);
		add_step("three_pending",       STEP_READ,   4'h1, 16'h0000, 4'b0000, 0, 16'h000e);
		add_step("enable_all",          STEP_WRITE,  4'h0, 16'h000f, 4'b0000, 8, 16'h0000);
		add_step("vsync_first",         STEP_OUTPUT, 4'h0, 16'h0000, 4'b0000, 0, 16'h0012);
		add_step("mask_vsync",          STEP_WRITE,  4'h0, 16'h000c, 4'b0000, 8, 16'h0000);
		add_step("audio_next",          STEP_OUTPUT, 4'h0, 16'h0000, 4'b0000, 0, 16'h0013);
		add_step("mask_audio",          STEP_WRITE,  4'h0, 16'h0008, 4'b0000, 8, 16'h0000);
		add_step("flash_next",          STEP_OUTPUT, 4'h0, 16'h0000, 4'b0000, 0, 16'h0014);
		add_step("mask_none",           STEP_WRITE,  4'h0, 16'h0000, 4'b0000, 8, 16'h0000);
		add_step("mask_drops_irq",      STEP_OUTPUT, 4'h0, 16'h0000, 4'b0000, 0, 16'h0000);
		add_step("enable_again",        STEP_WRITE,  4'h0, 16'h000f, 4'b0000, 8, 16'h0000);
		add_step("hsync_rise",          STEP_LINES,  4'h0, 16'h0000, 4'b1111, 8, 16'h0000);
		add_step("hsync_first",         STEP_OUTPUT, 4'h0, 16'h0000, 4'b0000, 0, 16'h0011);
		// a write to an unused address leaves the set pending bits alone.
		add_step("unused_write_9",      STEP_WRITE,  4'h9, 16'hffff, 4'b0000, 1, 16'h0000);
		add_step("unused_pending_kept", STEP_READ,   4'h1, 16'h0000, 4'b0000, 0, 16'h000f);
		// clearing pending bits.
		add_step("clear_hsync",         STEP_WRITE,  4'h1, 16'h0001, 4'b0000, 8, 16'h0000);
		add_step("hsync_cleared",       STEP_READ,   4'h1, 16'h0000, 4'b0000, 0, 16'h000e);
		add_step("vsync_after_clear",   STEP_OUTPUT, 4'h0, 16'h0000, 4'b0000, 0, 16'h0012);
		add_step("clear_vsync_audio",   STEP_WRITE,  4'h1, 16'h0006, 4'b0000, 8, 16'h0000);
		add_step("flash_left",          STEP_READ,   4'h1, 16'h0000, 4'b0000, 0, 16'h0008);
		add_step("flash_only",          STEP_OUTPUT, 4'h0, 16'h0000, 4'b0000, 0, 16'h0014);
		add_step("clear_flash",         STEP_WRITE,  4'h1, 16'h0008, 4'b0000, 8, 16'h0000);
		add_step("all_cleared",         STEP_READ,   4'h1, 16'h0000, 4'b0000, 0, 16'h0000);
		add_step("irq_dropped",         STEP_OUTPUT, 4'h0, 16'h0000, 4'b0000, 0, 16'h0000);
		// held lines do not set a cleared bit again, a new edge does.
		add_step("held_lines",          STEP_LINES,  4'h0, 16'h0000, 4'b1111, 8, 16'h0000);
		add_step("held_no_reset",       STEP_READ,   4'h1, 16'h0000, 4'b0000, 0, 16'h0000);
		add_step("lines_low",           STEP_LINES,  4'h0, 16'h0000, 4'b0000, 8, 16'h0000);
		add_step("low_no_pending",      STEP_READ,   4'h1, 16'h0000, 4'b0000, 0, 16'h0000);
		add_step("audio_rise_again",    STEP_LINES,  4'h0, 16'h0000, 4'b0100, 8, 16'h0000);
		add_step("audio_pending_again", STEP_READ,   4'h1, 16'h0000, 4'b0000, 0, 16'h0004);
		add_step("audio_irq",           STEP_OUTPUT, 4'h0, 16'h0000, 4'b0000, 0, 16'h0013);
		// repeated edges on a bit that is already pending merge.
		add_step("audio_low_1",         STEP_LINES,  4'h0, 16'h0000, 4'b0000, 3, 16'h0000);
		add_step("audio_high_1",        STEP_LINES,  4'h0, 16'h0000, 4'b0100, 3, 16'h0000);
		add_step("audio_low_2",         STEP_LINES,  4'h0, 16'h0000, 4'b0000, 3, 16'h0000);
		add_step("audio_high_2",        STEP_LINES,  4'h0, 16'h0000, 4'b0100, 8, 16'h0000);
		add_step("audio_merged",        STEP_READ,   4'h1, 16'h0000, 4'b0000, 0, 16'h0004);
		add_step("audio_irq_merged",    STEP_OUTPUT, 4'h0, 16'h0000, 4'b0000, 0, 16'h0013);
		add_step("clear_audio_once",    STEP_WRITE,  4'h1, 16'h0004, 4'b0000, 8, 16'h0000);
		add_step("audio_gone",          STEP_READ,   4'h1, 16'h0000, 4'b0000, 0, 16'h0000);
		add_step("final_quiet",         STEP_OUTPUT, 4'h0, 16'h0000, 4'b0000, 0, 16'h0000);
	endtask

`endif

/* sim/tb_irq_subsystem.sv */
// testbench for the interrupt block that applies a step table to the register port and request lines.

module tb_irq_subsystem;

	localparam int RESET_CYCLES = 16;
	localparam int CLK_HALF     = 50;

	logic               CLK;
	logic               RSTb;
	irq_pkg::irq_vec_t  irq_lines;
	irq_pkg::reg_addr_t address;
	irq_pkg::reg_data_t data_in;
	logic               wr;
	irq_pkg::reg_data_t data_out;
	logic               interrupt;
	irq_pkg::irq_num_t  irq_num;

	int errors;
	int checks;
	int cycles;
	int cycle_limit;

	`include "tb_irq_vectors.svh"

	//////////////////////////////////////////////////////////////////////
	// DUT and clock
	//////////////////////////////////////////////////////////////////////

	irq_subsystem_top DUT (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.irq_lines (irq_lines),
		.address   (address),
		.data_in   (data_in),
		.wr        (wr),
		.data_out  (data_out),
		.interrupt (interrupt),
		.irq_num   (irq_num)
	);

	always #CLK_HALF CLK = ~CLK;

	// the limit stays 0 until the table is loaded.
	always @(posedge CLK) begin
		cycles = cycles + 1;
		if (cycle_limit != 0 && cycles >= cycle_limit) begin
			$display("timeout: the step table did not finish within %0d cycles", cycle_limit);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	// step names sit right aligned in a packed vector, so the leading zero bytes are dropped.
	function automatic string name_text(input logic [NAME_BITS-1:0] name);
		string text;
		logic [7:0] ch;
		text = "";
		for (int i = NAME_BITS / 8 - 1; i >= 0; i--) begin
			ch = name[i*8 +: 8];
			if (ch != 8'h00) begin
				text = $sformatf("%s%c", text, ch);
			end
		end
		return text;
	endfunction

	function automatic int max_wait();
		int longest;
		longest = 0;
		foreach (steps[i]) begin
			if (steps[i].wait_cycles > longest) begin
				longest = steps[i].wait_cycles;
			end
		end
		return longest;
	endfunction

	task automatic check_value(
		input logic [NAME_BITS-1:0] name,
		input irq_pkg::reg_data_t   expected,
		input irq_pkg::reg_data_t   actual
	);
		checks = checks + 1;
		if (actual !== expected) begin
			$display("FAILED %s: expected 0x%04h, actual 0x%04h",
				name_text(name), expected, actual);
			errors = errors + 1;
		end
	endtask

	// every step starts on a falling edge, where inputs change and outputs are settled.
	task automatic run_step(input step_t s);
		irq_pkg::reg_data_t outputs;
		@(negedge CLK);
		case (s.kind)
			STEP_LINES: begin
				irq_lines = s.lines;
			end
			STEP_WRITE: begin
				address = s.addr;
				data_in = s.data;
				wr      = 1'b1;
				@(negedge CLK);
				wr      = 1'b0;
				data_in = '0;
			end
			STEP_READ: begin
				// read data is combinational, give it part of the low phase to settle.
				address = s.addr;
				#(CLK_HALF / 2);
				check_value(s.name, s.expected, data_out);
			end
			STEP_OUTPUT: begin
				outputs      = '0;
				outputs[4]   = interrupt;
				outputs[3:0] = irq_num;
				check_value(s.name, s.expected, outputs);
				if (interrupt !== (irq_num != 0)) begin
					$display("step %s: interrupt is %b while irq_num is %0d",
						name_text(s.name), interrupt, irq_num);
					errors = errors + 1;
				end
			end
		endcase
		repeat (s.wait_cycles) @(negedge CLK);
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		int longest;
		CLK         = 1'b0;
		RSTb        = 1'b0;
		irq_lines   = '0;
		address     = '0;
		data_in     = '0;
		wr          = 1'b0;
		errors      = 0;
		checks      = 0;
		cycles      = 0;
		cycle_limit = 0;

		load_steps();
		longest     = max_wait();
		cycle_limit = (steps.size() * longest + RESET_CYCLES) * 2;

		repeat (RESET_CYCLES) @(negedge CLK);
		RSTb = 1'b1;

		foreach (steps[i]) begin
			run_step(steps[i]);
		end

		$display("errors: %0d in %0d checks over %0d steps", errors, checks, steps.size());
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

/* rtl/irq_subsystem_top.sv */
// interrupt block top level joining the source, pending and priority stages.

module irq_subsystem_top (
	input  logic                CLK,
	input  logic                RSTb,
	input  irq_pkg::irq_vec_t   irq_lines,
	input  irq_pkg::reg_addr_t  address,
	input  irq_pkg::reg_data_t  data_in,
	input  logic                wr,
	output irq_pkg::reg_data_t  data_out,
	output logic                interrupt,
	output irq_pkg::irq_num_t   irq_num
);

	//////////////////////////////////////////////////////////////////////
	// stage links
	//////////////////////////////////////////////////////////////////////

	// edge pulses from the synchronizer.
	irq_pkg::src_stage_t src_stage;

	// enabled pending requests.
	irq_pkg::active_stage_t act_stage;

	//////////////////////////////////////////////////////////////////////
	// stages
	//////////////////////////////////////////////////////////////////////

	// peripheral lines in, one cycle pulse per rising edge out.
	irq_source_sync u_source_sync (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.irq_lines (irq_lines),
		.src       (src_stage)
	);

	// sticky pending bits, enable mask and the CPU register port.
	irq_pending_regs u_pending_regs (
		.CLK      (CLK),
		.RSTb     (RSTb),
		.src      (src_stage),
		.address  (address),
		.data_in  (data_in),
		.wr       (wr),
		.data_out (data_out),
		.act      (act_stage)
	);

	// request number and interrupt level to the CPU.
	irq_priority_encoder u_priority_encoder (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.act       (act_stage),
		.irq_num   (irq_num),
		.interrupt (interrupt)
	);

endmodule

/* rtl/irq_priority_encoder.sv */
// interrupt priority stage that registers the highest priority request number and the CPU interrupt.

module irq_priority_encoder (
	input  logic                    CLK,
	input  logic                    RSTb,
	input  irq_pkg::active_stage_t  act,
	output irq_pkg::irq_num_t       irq_num,
	output logic                    interrupt
);

	irq_pkg::irq_num_t num_next;
	logic              interrupt_next;

	irq_pkg::irq_num_t num_q;
	logic              interrupt_q;

	//////////////////////////////////////////////////////////////////////
	// fixed priority encoder
	//////////////////////////////////////////////////////////////////////

	// source 0 has the highest priority. The loop walks from the top
	// index down so that the lowest set bit is the last to be written.
	always_comb begin
		num_next = irq_pkg::IRQ_NUM_NONE;
		for (int i = irq_pkg::IRQ_COUNT - 1; i >= 0; i--) begin
			if (act.active[i]) begin
				num_next = irq_pkg::irq_num_t'(i + 1);
			end
		end
		interrupt_next = (num_next != irq_pkg::IRQ_NUM_NONE);
	end

	//////////////////////////////////////////////////////////////////////
	// output registers
	//////////////////////////////////////////////////////////////////////

	// both outputs come from flops, so the CPU sees them a cycle after
	// the active bits and never a glitch from the encoder.
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			num_q       <= irq_pkg::IRQ_NUM_NONE;
			interrupt_q <= 1'b0;
		end else begin
			num_q       <= num_next;
			interrupt_q <= interrupt_next;
		end
	end

	assign irq_num   = num_q;
	assign interrupt = interrupt_q;

endmodule

/* rtl/irq_pending_regs.sv */
// interrupt pending stage with the enable mask, the sticky pending bits and the CPU register port.

module irq_pending_regs (
	input  logic                    CLK,
	input  logic                    RSTb,
	input  irq_pkg::src_stage_t     src,
	input  irq_pkg::reg_addr_t      address,
	input  irq_pkg::reg_data_t      data_in,
	input  logic                    wr,
	output irq_pkg::reg_data_t      data_out,
	output irq_pkg::active_stage_t  act
);

	// enable mask, one bit per source.
	irq_pkg::irq_vec_t enable_q;

	// sticky pending bits.
	irq_pkg::irq_vec_t pending_q;

	// bits written to the pending register on the previous cycle.
	irq_pkg::irq_vec_t clear_q;

	//////////////////////////////////////////////////////////////////////
	// address decode
	//////////////////////////////////////////////////////////////////////

	logic wr_enable;
	logic wr_pending;
	irq_pkg::irq_vec_t wr_bits;

	assign wr_enable  = wr && (address == irq_pkg::ADDR_ENABLE);
	assign wr_pending = wr && (address == irq_pkg::ADDR_PENDING);

	// only the low data bits carry a source each; the rest are ignored.
	assign wr_bits = data_in[irq_pkg::IRQ_COUNT-1:0];

	//////////////////////////////////////////////////////////////////////
	// registers
	//////////////////////////////////////////////////////////////////////

	irq_pkg::irq_vec_t pending_next;

	// a request arriving in the same cycle as its clear wins, so no edge is lost.
	always_comb begin
		pending_next = (pending_q & ~clear_q) | src.req;
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			enable_q  <= '0;
			pending_q <= '0;
			clear_q   <= '0;
		end else begin
			if (wr_enable) begin
				enable_q <= wr_bits;
			end
			pending_q <= pending_next;
			// the clear mask only lives for the cycle after the write.
			clear_q <= wr_pending ? wr_bits : '0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// read port
	//////////////////////////////////////////////////////////////////////

	// reads are combinational from the address, unused addresses read zero.
	always_comb begin
		data_out = '0;
		case (address)
			irq_pkg::ADDR_ENABLE: begin
				data_out[irq_pkg::IRQ_COUNT-1:0] = enable_q;
			end
			irq_pkg::ADDR_PENDING: begin
				data_out[irq_pkg::IRQ_COUNT-1:0] = pending_q;
			end
			default: begin
				data_out = '0;
			end
		endcase
	end

	// pending requests that the CPU has not masked go on to the priority stage.
	assign act.active = pending_q & enable_q;

endmodule

/* rtl/irq_source_sync.sv */
// interrupt source stage that synchronizes the request lines and turns rising edges into pulses.

module irq_source_sync (
	input  logic                 CLK,
	input  logic                 RSTb,
	input  irq_pkg::irq_vec_t    irq_lines,
	output irq_pkg::src_stage_t  src
);

	//////////////////////////////////////////////////////////////////////
	// synchronizer
	//////////////////////////////////////////////////////////////////////

	// the peripheral lines may come from other clock domains, so each
	// one passes through two flops before any logic looks at it.
	irq_pkg::irq_vec_t sync_meta;
	irq_pkg::irq_vec_t sync_line;

	// the synchronized value of the previous cycle, for edge detection.
	irq_pkg::irq_vec_t sync_prev;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			sync_meta <= '0;
			sync_line <= '0;
		end else begin
			sync_meta <= irq_lines;
			sync_line <= sync_meta;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// edge detector
	//////////////////////////////////////////////////////////////////////

	// clearing the history on reset means a line that is already high
	// when reset ends is seen as one rising edge.
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			sync_prev <= '0;
		end else begin
			sync_prev <= sync_line;
		end
	end

	// a request pulse lasts exactly one cycle, however long the line stays high.
	// without this a held line would keep setting its pending bit and
	// a clear from the CPU would never stick.
	irq_pkg::irq_vec_t rise;

	always_comb begin
		rise = sync_line & ~sync_prev;
	end

	assign src.req = rise;

endmodule

/* rtl/irq_pkg.sv */
// interrupt block package with the register map, the vector types and the stage structs.

package irq_pkg;

	//////////////////////////////////////////////////////////////////////
	// sizes
	//////////////////////////////////////////////////////////////////////

	// one request source each for hsync, vsync, audio and spi flash.
	localparam int IRQ_COUNT = 4;

	// the CPU register port is 16 bits wide with a 4-bit address.
	localparam int DATA_WIDTH = 16;
	localparam int ADDR_WIDTH = 4;

	// the request number needs room for 0 (none) and 1 to 4.
	localparam int IRQ_NUM_WIDTH = 4;

	//////////////////////////////////////////////////////////////////////
	// vector types
	//////////////////////////////////////////////////////////////////////

	// bit 0 is hsync, bit 1 vsync, bit 2 audio and bit 3 spi flash.
	typedef logic [IRQ_COUNT-1:0] irq_vec_t;

	// 0 means no request, 1 to 4 name source 0 to 3.
	typedef logic [IRQ_NUM_WIDTH-1:0] irq_num_t;

	typedef logic [ADDR_WIDTH-1:0] reg_addr_t;
	typedef logic [DATA_WIDTH-1:0] reg_data_t;

	//////////////////////////////////////////////////////////////////////
	// register map
	//////////////////////////////////////////////////////////////////////

	// the enable mask reads and writes at address 0.
	localparam reg_addr_t ADDR_ENABLE = 4'h0;

	// pending bits read at address 1, and a write there clears the bits set in the data.
	localparam reg_addr_t ADDR_PENDING = 4'h1;

	// request number reported when no enabled bit is pending.
	localparam irq_num_t IRQ_NUM_NONE = 4'd0;

	//////////////////////////////////////////////////////////////////////
	// stage structs
	//////////////////////////////////////////////////////////////////////

	// source stage to pending stage.
	// each req bit is high for one cycle per rising edge on its line.
	typedef struct packed {
		irq_vec_t req;
	} src_stage_t;

	// pending stage to priority stage.
	// active is the pending bits masked by the enable bits.
	typedef struct packed {
		irq_vec_t active;
	} active_stage_t;

endpackage
